/* src.f */
source/qsnd_pkg.sv
source/qsnd_cpu_timing.sv
source/qsnd_bus_arbiter.sv
source/qsnd_memory_map.sv
source/qsnd_dsp_latch.sv
source/qsnd_sound_bus.sv
tb/tb_clock.sv
tb/tb_qsnd_sound_bus.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it, then look for the result line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --top-module tb_qsnd_sound_bus -f src.f -o tb_sim \
    && ./obj_dir/tb_sim | tee sim.log \
    || { echo "build or simulation did not complete"; exit 1; }
grep -q "Simulation finished: PASS" sim.log && exit 0 || exit 1

/* tb/tb_qsnd_sound_bus.sv */
/*
 * Sound board bus testbench
 * Directed tests for reset state, ROM and bank window, work RAM,
 * DSP command latch, sound CPU interrupt, main CPU bus takeover
 * and the sound CPU clock enable.
 * Inputs change on falling clk48 edges; a small ROM model feeds rom_data.
 */
`timescale 1ns/1ns
`default_nettype none

module tb_qsnd_sound_bus
    import qsnd_pkg::*;
();

    localparam int CEN_DIV    = 6;
    localparam int INT_PERIOD = 64;
    localparam int CLK_NS     = 8;
    localparam int HOLD       = 12;   // cycles per bus access

    // rough cycle budget of each test
    localparam int T_RESET = 20;
    localparam int T_ROM   = 80;
    localparam int T_RAM   = 800;
    localparam int T_CMD   = 100;
    localparam int T_INT   = 1200;
    localparam int T_BUS   = 60;
    localparam int T_CEN   = 120;
    localparam int WATCHDOG_NS =
        2 * CLK_NS * (T_RESET + T_ROM + T_RAM + T_CMD + T_INT + T_BUS + T_CEN);

    logic              clk48;
    logic              rst;
    cpu_bus_t          cpu;
    main_bus_t         main;
    logic              busak_n;
    logic              main_buse_n;
    logic [7:0]        rom_data;
    logic              rom_ok;
    logic              dsp_pids_n;
    logic              dsp_iack;
    logic [7:0]        cpu_din;
    logic              cpu_cen;
    logic              int_n;
    logic              busrq_n;
    logic [7:0]        main_din;
    logic              main_busakn;
    logic [ROM_AW-1:0] rom_addr;
    logic              rom_cs;
    logic [15:0]       dsp_cmd_word;
    logic              dsp_irq;
    logic              dsp_rst;

    int errors;
    int errors_at_start;
    int tests_passed;
    int tests_failed;

    tb_clock #(.PERIOD_NS(CLK_NS), .RESET_CYCLES(8)) u_clock (
        .clk48 (clk48),
        .rst   (rst)
    );

    qsnd_sound_bus #(
        .CEN_DIV    (CEN_DIV),
        .INT_PERIOD (INT_PERIOD)
    ) DUT (.*);

    // ROM model: low byte of the sum of the two address bytes
    function automatic logic [7:0] rom_byte(input logic [ROM_AW-1:0] a);
        return a[7:0] + a[15:8];
    endfunction

    assign rom_data = rom_byte(rom_addr);

    function automatic logic [15:0] ram_test_addr(input int i);
        return i < 16 ? 16'hc000 + 16'(i) : 16'hf010;
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk48);
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got == exp) else begin
            $display("Error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string msg);
        assert (cond) else begin
            $display("At %0t ns: %s", $time, msg);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        if (errors == errors_at_start) begin
            tests_passed++;
            $display("%0t ns: test %s ok", $time, name);
        end else begin
            tests_failed++;
            $display("%0t ns: test %s failed with %0d errors", $time, name,
                     errors - errors_at_start);
        end
    endtask

    // address and data stay put so the late select sees the same access
    task automatic release_cpu_bus();
        cpu.mreq_n = 1'b1;
        cpu.rd_n   = 1'b1;
        cpu.wr_n   = 1'b1;
        wait_cycles(2);
    endtask

    task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
        cpu.addr   = addr;
        cpu.dout   = data;
        cpu.mreq_n = 1'b0;
        cpu.wr_n   = 1'b0;
        wait_cycles(HOLD);
        release_cpu_bus();
    endtask

    task automatic cpu_read(input logic [15:0] addr, output logic [7:0] data,
                            output logic [ROM_AW-1:0] seen_addr);
        cpu.addr   = addr;
        cpu.mreq_n = 1'b0;
        cpu.rd_n   = 1'b0;
        wait_cycles(HOLD);
        data      = cpu_din;
        seen_addr = rom_addr;
        release_cpu_bus();
    endtask

    task automatic ack_interrupt();
        cpu.m1_n   = 1'b0;
        cpu.iorq_n = 1'b0;
        wait_cycles(HOLD);   // spans at least one enable tick
        cpu.m1_n   = 1'b1;
        cpu.iorq_n = 1'b1;
        wait_cycles(2);
    endtask

    // cpu_cen pulses seen over a window of clk48 cycles
    task automatic count_cpu_cen(input int cycles, output int pulses);
        pulses = 0;
        repeat (cycles) begin
            @(negedge clk48);
            if (cpu_cen)
                pulses++;
        end
    endtask

    task automatic take_bus();
        int n;
        main_buse_n = 1'b0;
        wait_cycles(1);
        check_true(!busrq_n, "busrq_n did not follow main_buse_n low");
        busak_n = 1'b0;
        n = 0;
        while (main_busakn && n < 3 * CEN_DIV) begin
            wait_cycles(1);
            n++;
        end
        check_true(!main_busakn, "main_busakn did not fall within 18 cycles of busak_n");
    endtask

    task automatic give_bus();
        main_buse_n = 1'b1;
        wait_cycles(1);
        check_true(main_busakn, "main_busakn stayed low after main_buse_n rose");
        check_true(busrq_n, "busrq_n stayed low after main_buse_n rose");
        busak_n = 1'b1;
        wait_cycles(1);
    endtask

    task automatic check_reset_outputs();
        check_value("int_n", 32'(int_n), 1);
        check_value("busrq_n", 32'(busrq_n), 1);
        check_value("main_busakn", 32'(main_busakn), 1);
        check_value("dsp_rdy_n", 32'(DUT.dsp_rdy_n), 1);
        check_value("rom_cs", 32'(rom_cs), 0);
        check_value("dsp_irq", 32'(dsp_irq), 0);
        check_value("dsp_rst", 32'(dsp_rst), 1);
    endtask

    task automatic test_reset();
        errors_at_start = errors;
        wait_cycles(3);
        check_reset_outputs();
        wait (!rst);
        wait_cycles(1);
        check_reset_outputs();
        end_test("reset");
    endtask

    task automatic test_rom_bank();
        logic [7:0]        d;
        logic [ROM_AW-1:0] a;
        logic [ROM_AW-1:0] exp_addr;
        errors_at_start = errors;
        cpu_read(16'h1234, d, a);
        check_value("rom_addr", 32'(a), 32'h01234);
        check_value("rom read data", 32'(d), 32'(rom_byte(19'h01234)));
        cpu_write(16'hd003, 8'h85);   // bank 5, DSP out of reset
        check_value("dsp_rst", 32'(dsp_rst), 0);
        exp_addr = BANK_BASE + (19'd5 << 14) + 19'h00123;
        cpu_read(16'h8123, d, a);
        check_value("banked rom_addr", 32'(a), 32'(exp_addr));
        check_value("banked read data", 32'(d), 32'(rom_byte(exp_addr)));
        cpu_read(16'hd007, d, a);
        check_value("status", 32'(d), 32'hf5);
        end_test("rom and bank");
    endtask

    task automatic test_work_ram();
        logic [7:0]        wdata [0:16];
        logic [7:0]        d;
        logic [7:0]        mdata;
        logic [ROM_AW-1:0] a;
        errors_at_start = errors;
        for (int i = 0; i < 17; i++) begin
            wdata[i] = 8'($urandom());
            cpu_write(ram_test_addr(i), wdata[i]);
        end
        for (int i = 0; i < 17; i++) begin
            cpu_read(ram_test_addr(i), d, a);
            check_value("ram read back", 32'(d), 32'(wdata[i]));
        end
        cpu_read(16'he000, d, a);
        check_value("unmapped read", 32'(d), 32'hff);
        // main CPU write then read through the shared bus
        mdata       = 8'($urandom());
        main.addr   = 16'hc020;
        main.dout   = mdata;
        main.ldsw_n = 1'b1;
        take_bus();
        main.ldsw_n = 1'b0;
        wait_cycles(HOLD);
        main.ldsw_n = 1'b1;
        wait_cycles(HOLD);
        check_value("main_din", 32'(main_din), 32'(mdata));
        give_bus();
        end_test("work ram");
    endtask

    task automatic test_dsp_command();
        logic [7:0]        h;
        logic [7:0]        l;
        logic [7:0]        cmd_addr;
        logic [7:0]        d;
        logic [ROM_AW-1:0] a;
        int                n;
        errors_at_start = errors;
        h        = 8'($urandom());
        l        = 8'($urandom());
        cmd_addr = 8'($urandom());
        cpu_write(16'hd000, h);
        cpu_write(16'hd001, l);
        cpu_write(16'hd002, cmd_addr);
        check_value("dsp_irq", 32'(dsp_irq), 1);
        check_value("dsp_cmd_word", 32'(dsp_cmd_word), 32'({8'h00, cmd_addr}));
        cpu_read(16'hd007, d, a);
        check_value("status with irq", 32'(d), 32'h75);   // rdy_n low and bank 5
        dsp_pids_n = 1'b0;
        wait_cycles(2);
        dsp_pids_n = 1'b1;
        n = 0;
        while (dsp_irq && n < 4) begin
            wait_cycles(1);
            n++;
        end
        check_true(!dsp_irq, "dsp_irq did not clear after the pids_n pulse");
        check_value("dsp_cmd_word data", 32'(dsp_cmd_word), 32'({h, l}));
        end_test("dsp command");
    endtask

    task automatic test_interrupt();
        int n;
        errors_at_start = errors;
        if (!int_n)
            ack_interrupt();   // earlier tests ran past a period
        n = 0;
        while (int_n && n < INT_PERIOD * CEN_DIV + 12) begin
            wait_cycles(1);
            n++;
        end
        check_true(!int_n, "int_n did not fall within one interrupt period");
        ack_interrupt();
        check_value("int_n after acknowledge", 32'(int_n), 1);
        end_test("interrupt");
    endtask

    task automatic test_bus_takeover();
        errors_at_start = errors;
        take_bus();
        give_bus();
        end_test("bus takeover");
    endtask

    task automatic test_cpu_enable();
        int pulses;
        errors_at_start = errors;
        count_cpu_cen(10 * CEN_DIV, pulses);
        check_value("idle cpu_cen ticks", 32'(pulses), 10);
        // opcode fetch at 0x4000 loses exactly one tick
        cpu.addr   = 16'h4000;
        cpu.mreq_n = 1'b0;
        cpu.rd_n   = 1'b0;
        cpu.m1_n   = 1'b0;
        count_cpu_cen(4 * CEN_DIV, pulses);
        check_value("cpu_cen ticks in a fetch at 0x4000", 32'(pulses), 3);
        cpu.m1_n = 1'b1;
        release_cpu_bus();
        // ROM not ready holds every tick
        cpu.addr   = 16'h0100;
        cpu.mreq_n = 1'b0;
        cpu.rd_n   = 1'b0;
        rom_ok     = 1'b0;
        count_cpu_cen(4 * CEN_DIV, pulses);
        check_value("rom_cs during a ROM read", 32'(rom_cs), 1);
        check_value("cpu_cen ticks while rom_ok is low", 32'(pulses), 0);
        rom_ok = 1'b1;
        release_cpu_bus();
        end_test("cpu clock enable");
    endtask

    initial begin
        void'($urandom(49));
        cpu = '{addr: 16'h0000, dout: 8'h00, mreq_n: 1'b1, rd_n: 1'b1,
                wr_n: 1'b1, m1_n: 1'b1, iorq_n: 1'b1};
        main        = '{addr: 16'h0000, dout: 8'h00, ldsw_n: 1'b1};
        busak_n     = 1'b1;
        main_buse_n = 1'b1;
        rom_ok      = 1'b1;
        dsp_pids_n  = 1'b1;
        dsp_iack    = 1'b0;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;

        test_reset();
        test_rom_bank();
        test_work_ram();
        test_dsp_command();
        test_interrupt();
        test_bus_takeover();
        test_cpu_enable();

        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

    // twice the summed test budgets
    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* tb/tb_clock.sv */
/*
 * Testbench clock and reset
 * Runs clk48 with an 8 ns period and holds rst high for the
 * first 8 cycles, releasing it on a falling edge.
 */
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 8
) (
    output logic clk48,
    output logic rst
);

    initial begin
        clk48 = 1'b0;
        forever #(PERIOD_NS / 2) clk48 = ~clk48;
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk48);
        @(negedge clk48);
        rst = 1'b0;   // released away from the active edge
    end

endmodule

`default_nettype wire

/* source/qsnd_sound_bus.sv */
/*
 * Sound board bus glue
 * Top level tying together CPU timing, main CPU bus takeover,
 * memory map and the DSP command latch, all on clk48.
 */
`timescale 1ns/1ns
`default_nettype none

module qsnd_sound_bus
    import qsnd_pkg::*;
#(
    parameter int CEN_DIV    = 6,
    parameter int INT_PERIOD = 64
) (
    input  wire              clk48,
    input  wire              rst,
    // sound CPU
    input  wire cpu_bus_t    cpu,
    input  wire              busak_n,
    output logic [7:0]       cpu_din,
    output logic             cpu_cen,
    output logic             int_n,
    output logic             busrq_n,
    // main CPU
    input  wire main_bus_t   main,
    input  wire              main_buse_n,
    output logic [7:0]       main_din,
    output logic             main_busakn,
    // program ROM
    input  wire [7:0]        rom_data,
    input  wire              rom_ok,
    output logic [ROM_AW-1:0] rom_addr,
    output logic             rom_cs,
    // DSP
    input  wire              dsp_pids_n,
    input  wire              dsp_iack,
    output logic [15:0]      dsp_cmd_word,
    output logic             dsp_irq,
    output logic             dsp_rst
);

    mem_bus_t bus;
    mem_sel_t sel;
    logic     cen8;
    logic     dsp_rdy_n;

    assign rom_cs = sel.rom_cs;

    qsnd_cpu_timing #(
        .CEN_DIV    (CEN_DIV),
        .INT_PERIOD (INT_PERIOD)
    ) u_timing (
        .clk48   (clk48),
        .rst     (rst),
        .m1_n    (cpu.m1_n),
        .iorq_n  (cpu.iorq_n),
        .addr_hi (cpu.addr[15:12]),
        .rom_cs  (sel.rom_cs),
        .rom_ok  (rom_ok),
        .cen8    (cen8),
        .cpu_cen (cpu_cen),
        .int_n   (int_n)
    );

    qsnd_bus_arbiter u_arbiter (
        .clk48       (clk48),
        .rst         (rst),
        .cen8        (cen8),
        .cpu         (cpu),
        .main        (main),
        .main_buse_n (main_buse_n),
        .busak_n     (busak_n),
        .rom_cs      (sel.rom_cs),
        .rom_ok      (rom_ok),
        .busrq_n     (busrq_n),
        .main_busakn (main_busakn),
        .bus         (bus)
    );

    qsnd_memory_map u_map (
        .clk48     (clk48),
        .rst       (rst),
        .bus       (bus),
        .rom_data  (rom_data),
        .dsp_rdy_n (dsp_rdy_n),
        .sel       (sel),
        .rom_addr  (rom_addr),
        .cpu_din   (cpu_din),
        .main_din  (main_din)
    );

    qsnd_dsp_latch u_latch (
        .clk48        (clk48),
        .rst          (rst),
        .bus          (bus),
        .sel          (sel),
        .dsp_pids_n   (dsp_pids_n),
        .dsp_iack     (dsp_iack),
        .dsp_cmd_word (dsp_cmd_word),
        .dsp_irq      (dsp_irq),
        .dsp_rdy_n    (dsp_rdy_n),
        .dsp_rst      (dsp_rst)
    );

endmodule

`default_nettype wire

/* source/qsnd_dsp_latch.sv */
/*
 * DSP command latch
 * Collects the three command bytes from the sound CPU, raises the DSP
 * interrupt and presents the command as two parallel words, address
 * first. Also drives the DSP reset from the bank register write.
 */
`timescale 1ns/1ns
`default_nettype none

module qsnd_dsp_latch
    import qsnd_pkg::*;
(
    input  wire           clk48,
    input  wire           rst,
    input  wire mem_bus_t bus,
    input  wire mem_sel_t sel,
    input  wire           dsp_pids_n,
    input  wire           dsp_iack,
    output logic [15:0]   dsp_cmd_word,
    output logic          dsp_irq,
    output logic          dsp_rdy_n,
    output logic          dsp_rst
);

    logic [23:0] cmd;        // {addr, data hi, data lo}
    logic [1:0]  word_sel;
    logic        last_pids_n;
    logic        pids_rise;
    logic        addr_wr;

    assign addr_wr   = sel.cmd_wr && bus.addr[2:0] == REG_CMD_ADDR;
    assign pids_rise = dsp_pids_n && !last_pids_n;
    assign dsp_rdy_n = ~(dsp_irq | dsp_iack);

    always_ff @(posedge clk48) begin
        if (sel.cmd_wr) begin
            case (bus.addr[2:0])
                REG_CMD_HI:   cmd[15:8]  <= bus.data;
                REG_CMD_LO:   cmd[7:0]   <= bus.data;
                REG_CMD_ADDR: cmd[23:16] <= bus.data;
                default: ;
            endcase
        end
    end

    // address word goes out first, data word after the first read strobe
    always_ff @(posedge clk48 or posedge rst) begin
        if (rst) begin
            dsp_irq     <= 1'b0;
            word_sel    <= 2'b00;
            last_pids_n <= 1'b1;
        end else begin
            last_pids_n <= dsp_pids_n;
            if (addr_wr) begin
                dsp_irq  <= 1'b1;
                word_sel <= 2'b11;
            end else if (pids_rise) begin
                dsp_irq  <= 1'b0;
                word_sel <= word_sel >> 1;
            end
        end
    end

    assign dsp_cmd_word = word_sel[1] ? {8'd0, cmd[23:16]} : cmd[15:0];

    always_ff @(posedge clk48 or posedge rst) begin
        if (rst)
            dsp_rst <= 1'b1;
        else if (sel.bank_wr)
            dsp_rst <= ~bus.data[7];   // bit 7 set runs the DSP
    end

endmodule

`default_nettype wire

/* source/qsnd_memory_map.sv */
/*
 * Sound CPU memory map
 * Decodes the shared bus into registered selects, forms the program ROM
 * address with the banked window, holds the bank register and the 8 kB
 * work RAM and muxes the read data back to both CPUs.
 */
`timescale 1ns/1ns
`default_nettype none

module qsnd_memory_map
    import qsnd_pkg::*;
(
    input  wire              clk48,
    input  wire              rst,
    input  wire mem_bus_t    bus,
    input  wire [7:0]        rom_data,
    input  wire              dsp_rdy_n,
    output mem_sel_t         sel,
    output logic [ROM_AW-1:0] rom_addr,
    output logic [7:0]       cpu_din,
    output logic [7:0]       main_din
);

    logic [BANK_W-1:0] bank;
    logic [7:0]        ram [0:2**RAM_AW-1];
    logic [7:0]        ram_dout;
    logic              ram_we;
    logic              rom_region;
    logic              ram_region;
    logic              reg_region;
    logic [3:0]        top_nib;

    assign top_nib    = bus.addr[15:12];
    assign rom_region = !bus.addr[15] || bus.addr[15:14] == 2'b10;
    assign ram_region = top_nib == RAM_REGION_A || top_nib == RAM_REGION_B;
    assign reg_region = top_nib == REG_REGION;

    always_ff @(posedge clk48 or posedge rst) begin
        if (rst) begin
            sel <= '0;
        end else begin
            sel.rom_cs    <= !bus.mreq_n && rom_region;
            sel.ram_cs    <= !bus.mreq_n && ram_region;
            sel.cmd_wr    <= !bus.mreq_n && !bus.wr_n && reg_region
                             && bus.addr[2:0] <= REG_CMD_ADDR;
            sel.bank_wr   <= !bus.mreq_n && !bus.wr_n && reg_region
                             && bus.addr[2:0] == REG_BANK;
            sel.status_rd <= !bus.mreq_n && !bus.rd_n && reg_region
                             && bus.addr[2:0] == REG_STATUS;
        end
    end

    // 0x8000-0xbfff is a 16 kB window into the banked area
    always_ff @(posedge clk48) begin
        if (!bus.mreq_n) begin
            if (bus.addr[15])
                rom_addr <= BANK_BASE + ROM_AW'({bank, bus.addr[13:0]});
            else
                rom_addr <= ROM_AW'(bus.addr[14:0]);
        end
    end

    always_ff @(posedge clk48 or posedge rst) begin
        if (rst)
            bank <= '0;
        else if (sel.bank_wr)
            bank <= bus.data[BANK_W-1:0];
    end

    assign ram_we = sel.ram_cs && !bus.wr_n;

    always_ff @(posedge clk48) begin
        if (ram_we)
            ram[bus.addr[RAM_AW-1:0]] <= bus.data;
        ram_dout <= ram[bus.addr[RAM_AW-1:0]];
    end

    always_comb begin
        if (sel.rom_cs)
            cpu_din = rom_data;   // no opcode decryption
        else if (sel.ram_cs)
            cpu_din = ram_dout;
        else if (sel.status_rd)
            cpu_din = {dsp_rdy_n, 3'b111, bank};
        else
            cpu_din = 8'hff;
    end

    // main CPU sees the same data a cycle later
    always_ff @(posedge clk48) begin
        main_din <= cpu_din;
    end

endmodule

`default_nettype wire

/* source/qsnd_bus_arbiter.sv */
/*
 * Main CPU bus takeover
 * Passes the bus request to the sound CPU, latches its grant over two
 * enable ticks and switches the shared bus over to the main CPU.
 */
`timescale 1ns/1ns
`default_nettype none

module qsnd_bus_arbiter
    import qsnd_pkg::*;
(
    input  wire       clk48,
    input  wire       rst,
    input  wire       cen8,
    input  wire       cpu_bus_t cpu,
    input  wire       main_bus_t main,
    input  wire       main_buse_n,
    input  wire       busak_n,
    input  wire       rom_cs,
    input  wire       rom_ok,
    output logic      busrq_n,
    output logic      main_busakn,
    output mem_bus_t  bus
);

    logic [1:0] grant;   // two stage grant latch, active low
    logic       hold;

    assign busrq_n     = main_buse_n;
    assign hold        = ~grant[1];
    assign main_busakn = grant[1] | (rom_cs & ~rom_ok);

    always_ff @(posedge clk48 or posedge rst) begin
        if (rst)
            grant <= 2'b11;
        else if (main_buse_n)
            grant <= 2'b11;   // released at once
        else if (cen8)
            grant <= {grant[0], busrq_n | busak_n};
    end

    assign bus.addr   = hold ? main.addr    : cpu.addr;
    assign bus.data   = hold ? main.dout    : cpu.dout;
    assign bus.mreq_n = hold ? ~hold        : cpu.mreq_n;
    assign bus.rd_n   = hold ? ~main.ldsw_n : cpu.rd_n;   // main reads when not writing
    assign bus.wr_n   = hold ? main.ldsw_n  : cpu.wr_n;

endmodule

`default_nettype wire

/* source/qsnd_cpu_timing.sv */
/*
 * Sound CPU timing
 * Derives the CPU clock enable from clk48, adds one wait tick on opcode
 * fetches above 0x4000, stalls on ROM not ready and generates the
 * periodic interrupt with its M1/IORQ acknowledge.
 */
`timescale 1ns/1ns
`default_nettype none

module qsnd_cpu_timing #(
    parameter int CEN_DIV    = 6,
    parameter int INT_PERIOD = 64
) (
    input  wire       clk48,
    input  wire       rst,
    input  wire       m1_n,
    input  wire       iorq_n,
    input  wire [3:0] addr_hi,
    input  wire       rom_cs,
    input  wire       rom_ok,
    output logic      cen8,
    output logic      cpu_cen,
    output logic      int_n
);

    localparam int DIV_W = CEN_DIV > 1 ? $clog2(CEN_DIV) : 1;
    localparam int INT_W = INT_PERIOD > 1 ? $clog2(INT_PERIOD) : 1;

    logic [DIV_W-1:0] div_cnt;
    logic [INT_W-1:0] tick_cnt;
    logic             idle;
    logic             waited;   // this fetch already paid its wait tick
    logic             tick_wrap;

    assign tick_wrap = tick_cnt == INT_W'(INT_PERIOD - 1);
    assign cpu_cen   = cen8 & ~idle & ~(rom_cs & ~rom_ok);

    always_ff @(posedge clk48 or posedge rst) begin
        if (rst) begin
            div_cnt <= '0;
            cen8    <= 1'b0;
        end else begin
            cen8    <= div_cnt == DIV_W'(CEN_DIV - 1);
            div_cnt <= div_cnt == DIV_W'(CEN_DIV - 1) ? '0 : div_cnt + 1'b1;
        end
    end

    // extra wait state on fetches from 0x4000 up
    always_ff @(posedge clk48 or posedge rst) begin
        if (rst) begin
            idle   <= 1'b0;
            waited <= 1'b0;
        end else begin
            if (m1_n) waited <= 1'b0;
            if (cen8) begin
                if (idle) begin
                    idle   <= 1'b0;
                    waited <= 1'b1;
                end else if (!m1_n && addr_hi >= 4'h4 && !waited) begin
                    idle <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk48 or posedge rst) begin
        if (rst) begin
            tick_cnt <= '0;
            int_n    <= 1'b1;
        end else if (cen8) begin
            tick_cnt <= tick_wrap ? '0 : tick_cnt + 1'b1;
            if (!m1_n && !iorq_n)
                int_n <= 1'b1;   // acknowledge cycle
            else if (tick_wrap)
                int_n <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* source/qsnd_pkg.sv */
/*
 * Sound board bus definitions
 * Bus structs for the sound CPU, the main CPU and the shared memory bus,
 * the registered select bundle and the memory-map constants.
 */
`default_nettype none

package qsnd_pkg;

    localparam int ROM_AW = 19;   // 512 kB program ROM
    localparam int RAM_AW = 13;   // 8 kB work RAM
    localparam int BANK_W = 4;

    localparam logic [ROM_AW-1:0] BANK_BASE = 19'h08000;

    // top address nibbles
    localparam logic [3:0] RAM_REGION_A = 4'hc;
    localparam logic [3:0] RAM_REGION_B = 4'hf;
    localparam logic [3:0] REG_REGION   = 4'hd;

    // register offsets in A[2:0]
    localparam logic [2:0] REG_CMD_HI   = 3'd0;
    localparam logic [2:0] REG_CMD_LO   = 3'd1;
    localparam logic [2:0] REG_CMD_ADDR = 3'd2;
    localparam logic [2:0] REG_BANK     = 3'd3;
    localparam logic [2:0] REG_STATUS   = 3'd7;

    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  dout;
        logic        mreq_n;
        logic        rd_n;
        logic        wr_n;
        logic        m1_n;
        logic        iorq_n;
    } cpu_bus_t;

    typedef struct packed {
        logic [15:0] addr;     // main address bits 16:1
        logic [7:0]  dout;
        logic        ldsw_n;
    } main_bus_t;

    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  data;
        logic        mreq_n;
        logic        rd_n;
        logic        wr_n;
    } mem_bus_t;

    typedef struct packed {
        logic rom_cs;
        logic ram_cs;
        logic cmd_wr;
        logic bank_wr;
        logic status_rd;
    } mem_sel_t;

endpackage

`default_nettype wire
